// File: design/bus_settings.svh
// --------------------------------------
// board constants for the main 68000 bus
// include in any file that decodes or sizes the bus
// --------------------------------------
`ifndef BUS_SETTINGS_SVH
`define BUS_SETTINGS_SVH

`define BUS_AW        23          // word address, a[23:1]
`define BUS_DW        16
`define WRAM_AW       15          // 64KB work RAM
`define PALRAM_AW     11          // 4KB palette

// region patterns, compared against the byte address
`define REGION_WRAM   8'h10       // a[23:16]
`define REGION_GCU    4'h3        // a[23:20]
`define REGION_PAL    4'h4        // a[23:20], palette aliases over it
`define REGION_SND    4'h6        // a[23:20]
`define IO_PAGE       12'h21C     // a[23:12]

// I/O page byte offsets
`define IO_IN1        12'h020
`define IO_IN2        12'h024
`define IO_SYS        12'h028
`define IO_DSWA       12'h02C
`define IO_DSWB       12'h030
`define IO_JMPR       12'h034
`define IO_VCOUNT     12'h03C

// GP9001 register offsets
`define GCU_SET_PTR   4'h0
`define GCU_RAM_H     4'h4
`define GCU_RAM_L     4'h6
`define GCU_SELECT    4'h8
`define GCU_WRITE_REG 4'hC

`endif

// File: design/bus_pkg.sv
// --------------------------------------
// bus-side types shared by the three stages
// region select, offset views and the bus word
// --------------------------------------
`include "bus_settings.svh"

package bus_pkg;

    // which device a cycle lands on
    typedef enum logic [2:0] {
        REG_NONE,
        REG_WRAM,
        REG_PAL,
        REG_GCU,
        REG_IO,
        REG_SND
    } region_t;

    // low 12 byte-address bits
    // io page uses the full offset, GP9001 only a 4-bit register field
    typedef union packed {
        logic [11:0] io;
        struct packed {
            logic [7:0] unused;
            logic [3:0] reg_field;
        } gcu;
    } bus_offset_u;

    typedef logic [`BUS_DW-1:0] bus_word_t;

endpackage

// File: design/cabinet_pkg.sv
// --------------------------------------
// cabinet input word layouts
// bits are active high on the bus, inputs arrive active low
// --------------------------------------
package cabinet_pkg;

    typedef struct packed {
        logic spare;        // always 0
        logic btn3;
        logic btn2;
        logic btn1;
        logic right;
        logic left;
        logic down;
        logic up;
    } player_byte_t;

    typedef struct packed {
        logic [7:0] dip_c;
        logic       zero_hi;
        logic       start2_n;
        logic       start1_n;
        logic       coin2_n;
        logic       coin1_n;
        logic       test_n;
        logic       zero_lo;
        logic       service_n;
    } system_word_t;

endpackage

// File: design/bus_decode.sv
// --------------------------------------
// first stage of the main bus
// latches each 68000 cycle and finds its region;
// start pulses once, one edge after as_n is first seen low
// --------------------------------------
`include "bus_settings.svh"

module bus_decode (
    input  logic                 CLK96,
    input  logic                 RESET96,
    input  logic                 as_n,
    input  logic                 rw,
    input  logic                 uds_n,
    input  logic                 lds_n,
    input  logic [`BUS_AW-1:0]   addr,
    input  bus_pkg::bus_word_t   wdata,
    output logic                 start,
    output bus_pkg::region_t     region,
    output bus_pkg::bus_offset_u offset,
    output logic [`BUS_AW-1:0]   word_addr,
    output logic                 rw_q,
    output logic [1:0]           ben,
    output bus_pkg::bus_word_t   wdata_q
);
    import bus_pkg::*;

    logic [23:0] byte_addr;
    logic        as_q;
    logic        as_prev;
    region_t     region_d;

    assign byte_addr = {addr, 1'b0};   // follows the memory map

    always_comb begin
        if (byte_addr[23:16] == `REGION_WRAM)
            region_d = REG_WRAM;
        else if (byte_addr[23:12] == `IO_PAGE)
            region_d = REG_IO;
        else if (byte_addr[23:20] == `REGION_GCU)
            region_d = REG_GCU;
        else if (byte_addr[23:20] == `REGION_PAL)
            region_d = REG_PAL;
        else if (byte_addr[23:20] == `REGION_SND)
            region_d = REG_SND;
        else
            region_d = REG_NONE;
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            as_q    <= 1'b1;
            as_prev <= 1'b1;
            start   <= 1'b0;
            region  <= REG_NONE;
            rw_q    <= 1'b1;
            ben     <= 2'b00;
        end else begin
            as_q    <= as_n;
            as_prev <= as_q;
            start   <= as_prev & ~as_q;      // falling edge of as_n
            if (!as_n) begin
                region <= region_d;
                rw_q   <= rw;
                ben    <= {~uds_n, ~lds_n};  // upper lane in bit 1
            end
        end
    end

    // address and data, held for the whole cycle
    always_ff @(posedge CLK96) begin
        if (!as_n) begin
            word_addr <= addr;
            offset.io <= byte_addr[11:0];
            wdata_q   <= wdata;
        end
    end

endmodule

// File: design/cpu_ram.sv
// --------------------------------------
// dual-port word RAM, one cycle read latency
// port A reads and writes per byte lane, port B only reads
// --------------------------------------
`include "bus_settings.svh"

module cpu_ram (
    input  logic                CLK96,
    input  logic [`WRAM_AW-1:0] a_addr,
    input  bus_pkg::bus_word_t  a_data,
    input  logic [1:0]          a_we,
    input  logic [`WRAM_AW-1:0] b_addr,
    output bus_pkg::bus_word_t  a_q,
    output bus_pkg::bus_word_t  b_q
);
    import bus_pkg::*;

    // depth follows the address port width
    localparam int DEPTH = 2 ** $bits(a_addr);

    bus_word_t mem [DEPTH];

    always_ff @(posedge CLK96) begin
        if (a_we[1])
            mem[a_addr][15:8] <= a_data[15:8];
        if (a_we[0])
            mem[a_addr][7:0] <= a_data[7:0];
        a_q <= mem[a_addr];                  // old data on a write
    end

    always_ff @(posedge CLK96) begin
        b_q <= mem[b_addr];
    end

endmodule

// File: design/access_execute.sv
// --------------------------------------
// second stage of the main bus
// RAM write enables, GP9001 strobes, sound latch and the
// I/O read words; exec_data and done land one edge after start
// --------------------------------------
`include "bus_settings.svh"

module access_execute (
    input  logic                 CLK96,
    input  logic                 RESET96,
    input  logic                 start,
    input  bus_pkg::region_t     region,
    input  bus_pkg::bus_offset_u offset,
    input  logic                 rw_q,
    input  logic [1:0]           ben,
    input  bus_pkg::bus_word_t   wdata_q,
    input  bus_pkg::bus_word_t   wram_q,
    input  bus_pkg::bus_word_t   pal_q,
    input  logic                 gp9001_ack,
    input  logic [9:0]           joystick1,
    input  logic [9:0]           joystick2,
    input  logic [3:0]           start_button,
    input  logic [3:0]           coin_input,
    input  logic                 service,
    input  logic                 dip_test,
    input  logic [7:0]           dipsw_a,
    input  logic [7:0]           dipsw_b,
    input  logic [7:0]           dipsw_c,
    input  logic [8:0]           v,
    input  logic                 hsync,
    input  logic                 vsync,
    input  logic                 fblank,
    output logic [1:0]           wram_we,
    output logic [1:0]           pal_we,
    output logic                 done,
    output bus_pkg::bus_word_t   exec_data,
    output logic                 gcu_pending,
    output logic                 gp9001_op_select_reg,
    output logic                 gp9001_op_write_reg,
    output logic                 gp9001_op_write_ram,
    output logic                 gp9001_op_read_ram_h,
    output logic                 gp9001_op_read_ram_l,
    output logic                 gp9001_op_set_ram_ptr,
    output logic [7:0]           soundlatch,
    output logic                 z80int
);
    import bus_pkg::*;
    import cabinet_pkg::*;

    player_byte_t p1;
    player_byte_t p2;
    system_word_t sys_word;
    bus_word_t    vstatus;
    bus_word_t    io_word;
    bus_word_t    read_word;
    logic         wr_cycle;

    // joystick inputs are active low
    function automatic player_byte_t player_byte(input logic [9:0] joy);
        player_byte_t pb;
        pb.spare = 1'b0;
        pb.btn3  = ~joy[6];
        pb.btn2  = ~joy[5];
        pb.btn1  = ~joy[4];
        pb.right = ~joy[0];
        pb.left  = ~joy[1];
        pb.down  = ~joy[2];
        pb.up    = ~joy[3];
        return pb;
    endfunction

    assign p1 = player_byte(joystick1);
    assign p2 = player_byte(joystick2);

    always_comb begin
        sys_word.dip_c     = dipsw_c;
        sys_word.zero_hi   = 1'b0;
        sys_word.start2_n  = ~start_button[1];
        sys_word.start1_n  = ~start_button[0];
        sys_word.coin2_n   = ~coin_input[1];
        sys_word.coin1_n   = ~coin_input[0];
        sys_word.test_n    = ~dip_test;
        sys_word.zero_lo   = 1'b0;
        sys_word.service_n = ~service;
    end

    // line counter saturates at 0xFF past the visible range
    assign vstatus = {hsync, vsync, 5'b11111, fblank, v[8] ? 8'hFF : v[7:0]};

    always_comb begin
        case (offset.io)
            `IO_IN1:    io_word = {2{p1}};
            `IO_IN2:    io_word = {2{p2}};
            `IO_SYS:    io_word = sys_word;
            `IO_DSWA:   io_word = {2{dipsw_a}};
            `IO_DSWB:   io_word = {2{dipsw_b}};
            `IO_JMPR:   io_word = {2{dipsw_c}};
            `IO_VCOUNT: io_word = vstatus;
            default:    io_word = '0;
        endcase
    end

    always_comb begin
        case (region)
            REG_WRAM: read_word = wram_q;
            REG_PAL:  read_word = pal_q;
            REG_IO:   read_word = io_word;
            default:  read_word = '0;   // GP9001 data comes in the result stage
        endcase
    end

    assign wr_cycle = start & ~rw_q;
    assign wram_we  = (wr_cycle && region == REG_WRAM) ? ben : 2'b00;
    assign pal_we   = (wr_cycle && region == REG_PAL) ? ben : 2'b00;

    assign gcu_pending = |{gp9001_op_select_reg, gp9001_op_write_reg, gp9001_op_write_ram,
                           gp9001_op_read_ram_h, gp9001_op_read_ram_l, gp9001_op_set_ram_ptr};

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            done                  <= 1'b0;
            soundlatch            <= 8'h00;
            z80int                <= 1'b0;
            gp9001_op_select_reg  <= 1'b0;
            gp9001_op_write_reg   <= 1'b0;
            gp9001_op_write_ram   <= 1'b0;
            gp9001_op_read_ram_h  <= 1'b0;
            gp9001_op_read_ram_l  <= 1'b0;
            gp9001_op_set_ram_ptr <= 1'b0;
        end else begin
            done   <= start;
            z80int <= 1'b0;
            if (gp9001_ack) begin                // ack drops every strobe at once
                gp9001_op_select_reg  <= 1'b0;
                gp9001_op_write_reg   <= 1'b0;
                gp9001_op_write_ram   <= 1'b0;
                gp9001_op_read_ram_h  <= 1'b0;
                gp9001_op_read_ram_l  <= 1'b0;
                gp9001_op_set_ram_ptr <= 1'b0;
            end
            if (wr_cycle && region == REG_SND) begin
                soundlatch <= wdata_q[7:0];
                z80int     <= 1'b1;
            end
            if (start && region == REG_GCU) begin
                if (rw_q) begin
                    case (offset.gcu.reg_field)
                        `GCU_RAM_H: gp9001_op_read_ram_h <= 1'b1;
                        `GCU_RAM_L: gp9001_op_read_ram_l <= 1'b1;
                        default: ;                      // completes with 0
                    endcase
                end else begin
                    case (offset.gcu.reg_field)
                        `GCU_SET_PTR:          gp9001_op_set_ram_ptr <= 1'b1;
                        `GCU_RAM_H, `GCU_RAM_L: gp9001_op_write_ram  <= 1'b1;
                        `GCU_SELECT:           gp9001_op_select_reg  <= 1'b1;
                        `GCU_WRITE_REG:        gp9001_op_write_reg   <= 1'b1;
                        default: ;
                    endcase
                end
            end
        end
    end

    // writes return 0
    always_ff @(posedge CLK96) begin
        if (start)
            exec_data <= rw_q ? read_word : '0;
    end

endmodule

// File: design/read_result.sv
// --------------------------------------
// last stage of the main bus
// holds the read word and drives dtack_n until as_n rises;
// GP9001 cycles wait for the chip's acknowledge
// --------------------------------------
module read_result (
    input  logic               CLK96,
    input  logic               RESET96,
    input  logic               as_n,
    input  logic               done,
    input  bus_pkg::bus_word_t exec_data,
    input  logic               gcu_pending,
    input  logic               gp9001_ack,
    input  bus_pkg::bus_word_t gp9001_dout,
    output bus_pkg::bus_word_t rdata,
    output logic               dtack_n
);

    logic gcu_wait;   // strobe out, no ack yet

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            rdata    <= '0;
            dtack_n  <= 1'b1;
            gcu_wait <= 1'b0;
        end else if (as_n) begin
            dtack_n  <= 1'b1;                 // master released the bus
            gcu_wait <= 1'b0;
        end else if (done && !gcu_pending) begin
            rdata   <= exec_data;
            dtack_n <= 1'b0;
        end else if ((done || gcu_wait) && gp9001_ack) begin
            rdata    <= gp9001_dout;          // sampled on the ack edge
            dtack_n  <= 1'b0;
            gcu_wait <= 1'b0;
        end else if (done) begin
            gcu_wait <= 1'b1;
        end
    end

endmodule

// File: design/garegga_main_bus.sv
// --------------------------------------
// main bus of the Garegga board, CPU side
// an external 68000-style master drives as_n/rw/strobes;
// palette RAM has a second read port for the video side
// --------------------------------------
`include "bus_settings.svh"

module garegga_main_bus (
    input  logic                  CLK96,
    input  logic                  RESET96,
    input  logic                  as_n,
    input  logic                  rw,
    input  logic                  uds_n,
    input  logic                  lds_n,
    input  logic [`BUS_AW-1:0]    addr,
    input  bus_pkg::bus_word_t    wdata,
    output bus_pkg::bus_word_t    rdata,
    output logic                  dtack_n,
    input  logic                  gp9001_ack,
    input  bus_pkg::bus_word_t    gp9001_dout,
    output logic                  gp9001_op_select_reg,
    output logic                  gp9001_op_write_reg,
    output logic                  gp9001_op_write_ram,
    output logic                  gp9001_op_read_ram_h,
    output logic                  gp9001_op_read_ram_l,
    output logic                  gp9001_op_set_ram_ptr,
    output logic [7:0]            soundlatch,
    output logic                  z80int,
    input  logic [9:0]            joystick1,
    input  logic [9:0]            joystick2,
    input  logic [3:0]            start_button,
    input  logic [3:0]            coin_input,
    input  logic                  service,
    input  logic                  dip_test,
    input  logic [7:0]            dipsw_a,
    input  logic [7:0]            dipsw_b,
    input  logic [7:0]            dipsw_c,
    input  logic [8:0]            v,
    input  logic                  hsync,
    input  logic                  vsync,
    input  logic                  fblank,
    input  logic [`PALRAM_AW-1:0] palram_addr,
    output bus_pkg::bus_word_t    palram_data
);

    localparam int PAD = `WRAM_AW - `PALRAM_AW;   // palette sits in the low words

    logic                 start;
    bus_pkg::region_t     region;
    bus_pkg::bus_offset_u offset;
    logic [`BUS_AW-1:0]   word_addr;
    logic                 rw_q;
    logic [1:0]           ben;
    bus_pkg::bus_word_t   wdata_q;
    logic [1:0]           wram_we;
    logic [1:0]           pal_we;
    bus_pkg::bus_word_t   wram_q;
    bus_pkg::bus_word_t   pal_q;
    logic                 done;
    bus_pkg::bus_word_t   exec_data;
    logic                 gcu_pending;

    bus_decode u_bus_decode (
        .CLK96     (CLK96),
        .RESET96   (RESET96),
        .as_n      (as_n),
        .rw        (rw),
        .uds_n     (uds_n),
        .lds_n     (lds_n),
        .addr      (addr),
        .wdata     (wdata),
        .start     (start),
        .region    (region),
        .offset    (offset),
        .word_addr (word_addr),
        .rw_q      (rw_q),
        .ben       (ben),
        .wdata_q   (wdata_q)
    );

    // work RAM 0x100000-0x10FFFF, port B idle
    cpu_ram u_wram (
        .CLK96  (CLK96),
        .a_addr (word_addr[`WRAM_AW-1:0]),
        .a_data (wdata_q),
        .a_we   (wram_we),
        .b_addr ({`WRAM_AW{1'b0}}),
        .a_q    (wram_q),
        .b_q    ()
    );

    // palette 0x400000-0x400FFF, port B to video
    cpu_ram u_palram (
        .CLK96  (CLK96),
        .a_addr ({{PAD{1'b0}}, word_addr[`PALRAM_AW-1:0]}),
        .a_data (wdata_q),
        .a_we   (pal_we),
        .b_addr ({{PAD{1'b0}}, palram_addr}),
        .a_q    (pal_q),
        .b_q    (palram_data)
    );

    access_execute u_access_execute (
        .CLK96                 (CLK96),
        .RESET96               (RESET96),
        .start                 (start),
        .region                (region),
        .offset                (offset),
        .rw_q                  (rw_q),
        .ben                   (ben),
        .wdata_q               (wdata_q),
        .wram_q                (wram_q),
        .pal_q                 (pal_q),
        .gp9001_ack            (gp9001_ack),
        .joystick1             (joystick1),
        .joystick2             (joystick2),
        .start_button          (start_button),
        .coin_input            (coin_input),
        .service               (service),
        .dip_test              (dip_test),
        .dipsw_a               (dipsw_a),
        .dipsw_b               (dipsw_b),
        .dipsw_c               (dipsw_c),
        .v                     (v),
        .hsync                 (hsync),
        .vsync                 (vsync),
        .fblank                (fblank),
        .wram_we               (wram_we),
        .pal_we                (pal_we),
        .done                  (done),
        .exec_data             (exec_data),
        .gcu_pending           (gcu_pending),
        .gp9001_op_select_reg  (gp9001_op_select_reg),
        .gp9001_op_write_reg   (gp9001_op_write_reg),
        .gp9001_op_write_ram   (gp9001_op_write_ram),
        .gp9001_op_read_ram_h  (gp9001_op_read_ram_h),
        .gp9001_op_read_ram_l  (gp9001_op_read_ram_l),
        .gp9001_op_set_ram_ptr (gp9001_op_set_ram_ptr),
        .soundlatch            (soundlatch),
        .z80int                (z80int)
    );

    read_result u_read_result (
        .CLK96       (CLK96),
        .RESET96     (RESET96),
        .as_n        (as_n),
        .done        (done),
        .exec_data   (exec_data),
        .gcu_pending (gcu_pending),
        .gp9001_ack  (gp9001_ack),
        .gp9001_dout (gp9001_dout),
        .rdata       (rdata),
        .dtack_n     (dtack_n)
    );

endmodule

// File: verification/bus_vectors.svh
// ----------------------------------------
// stimulus and expected values for the main bus testbench
// one row per 68000 cycle, included inside the testbench module
// ----------------------------------------
`ifndef BUS_VECTORS_SVH
`define BUS_VECTORS_SVH

// cabinet inputs, held for the whole run
localparam logic [9:0] JOY1       = 10'h3A6;   // player byte 0x59
localparam logic [9:0] JOY2       = 10'h05B;   // player byte 0x22
localparam logic [3:0] START_IN   = 4'b0001;
localparam logic [3:0] COIN_IN    = 4'b0010;
localparam logic       SERVICE_IN = 1'b1;
localparam logic       TEST_IN    = 1'b0;
localparam logic [7:0] DSW_A      = 8'h5A;
localparam logic [7:0] DSW_B      = 8'h81;
localparam logic [7:0] DSW_C      = 8'hC3;
localparam logic       HSYNC_IN   = 1'b1;
localparam logic       VSYNC_IN   = 1'b0;
localparam logic       FBLANK_IN  = 1'b1;

typedef struct packed {
    logic        rw;
    logic [1:0]  ben;          // {upper, lower} byte lanes
    logic [23:0] byte_addr;
    bus_word_t   wdata;
    bus_word_t   gdout;        // gp9001_dout during the cycle
    logic [8:0]  v_in;
    bus_word_t   exp_rdata;    // also palram_data when pal_chk set
    logic [5:0]  exp_strobe;   // select, write_reg, write_ram, read_h, read_l, set_ptr
    logic [7:0]  exp_latch;
    logic        exp_int;
    logic        pal_chk;
} access_vec_t;

localparam int NUM_VEC = 33;

// rw ben addr wdata gdout v | rdata strobe latch int pal
localparam access_vec_t VECTORS [NUM_VEC] = '{
    '{1'b0, 2'b11, 24'h100010, 16'h1234, 16'h0000, 9'h000, 16'h0000, 6'h00, 8'h00, 1'b0, 1'b0},
    '{1'b0, 2'b01, 24'h100010, 16'hAB77, 16'h0000, 9'h000, 16'h0000, 6'h00, 8'h00, 1'b0, 1'b0},
    '{1'b1, 2'b11, 24'h100010, 16'h0000, 16'h0000, 9'h000, 16'h1277, 6'h00, 8'h00, 1'b0, 1'b0},
    '{1'b0, 2'b11, 24'h10FFFE, 16'hBEEF, 16'h0000, 9'h000, 16'h0000, 6'h00, 8'h00, 1'b0, 1'b0},
    '{1'b0, 2'b10, 24'h10FFFE, 16'h4100, 16'h0000, 9'h000, 16'h0000, 6'h00, 8'h00, 1'b0, 1'b0},
    '{1'b1, 2'b11, 24'h10FFFE, 16'h0000, 16'h0000, 9'h000, 16'h41EF, 6'h00, 8'h00, 1'b0, 1'b0},
    '{1'b0, 2'b11, 24'h400020, 16'hCAFE, 16'h0000, 9'h000, 16'h0000, 6'h00, 8'h00, 1'b0, 1'b0},
    '{1'b1, 2'b11, 24'h400020, 16'h0000, 16'h0000, 9'h000, 16'hCAFE, 6'h00, 8'h00, 1'b0, 1'b1},
    '{1'b0, 2'b11, 24'h4A0042, 16'h0F0F, 16'h0000, 9'h000, 16'h0000, 6'h00, 8'h00, 1'b0, 1'b0},
    '{1'b1, 2'b11, 24'h400042, 16'h0000, 16'h0000, 9'h000, 16'h0F0F, 6'h00, 8'h00, 1'b0, 1'b1},
    '{1'b1, 2'b11, 24'h21C020, 16'h0000, 16'h0000, 9'h000, 16'h5959, 6'h00, 8'h00, 1'b0, 1'b0},
    '{1'b1, 2'b11, 24'h21C024, 16'h0000, 16'h0000, 9'h000, 16'h2222, 6'h00, 8'h00, 1'b0, 1'b0},
    '{1'b1, 2'b11, 24'h21C028, 16'h0000, 16'h0000, 9'h000, 16'hC34C, 6'h00, 8'h00, 1'b0, 1'b0},
    '{1'b1, 2'b11, 24'h21C02C, 16'h0000, 16'h0000, 9'h000, 16'h5A5A, 6'h00, 8'h00, 1'b0, 1'b0},
    '{1'b1, 2'b11, 24'h21C030, 16'h0000, 16'h0000, 9'h000, 16'h8181, 6'h00, 8'h00, 1'b0, 1'b0},
    '{1'b1, 2'b11, 24'h21C034, 16'h0000, 16'h0000, 9'h000, 16'hC3C3, 6'h00, 8'h00, 1'b0, 1'b0},
    '{1'b1, 2'b11, 24'h21C03C, 16'h0000, 16'h0000, 9'h07E, 16'hBF7E, 6'h00, 8'h00, 1'b0, 1'b0},
    '{1'b1, 2'b11, 24'h21C03C, 16'h0000, 16'h0000, 9'h123, 16'hBFFF, 6'h00, 8'h00, 1'b0, 1'b0},
    '{1'b1, 2'b11, 24'h21C038, 16'h0000, 16'h0000, 9'h000, 16'h0000, 6'h00, 8'h00, 1'b0, 1'b0},
    '{1'b0, 2'b11, 24'h300000, 16'h0010, 16'h0000, 9'h000, 16'h0000, 6'h01, 8'h00, 1'b0, 1'b0},
    '{1'b0, 2'b11, 24'h300004, 16'h1111, 16'h0000, 9'h000, 16'h0000, 6'h08, 8'h00, 1'b0, 1'b0},
    '{1'b0, 2'b11, 24'h300006, 16'h2222, 16'h0000, 9'h000, 16'h0000, 6'h08, 8'h00, 1'b0, 1'b0},
    '{1'b0, 2'b11, 24'h300008, 16'h0003, 16'h0000, 9'h000, 16'h0000, 6'h20, 8'h00, 1'b0, 1'b0},
    '{1'b0, 2'b11, 24'h30000C, 16'h00FF, 16'h0000, 9'h000, 16'h0000, 6'h10, 8'h00, 1'b0, 1'b0},
    '{1'b1, 2'b11, 24'h300004, 16'h0000, 16'h9A31, 9'h000, 16'h9A31, 6'h04, 8'h00, 1'b0, 1'b0},
    '{1'b1, 2'b11, 24'h300006, 16'h0000, 16'h6E02, 9'h000, 16'h6E02, 6'h02, 8'h00, 1'b0, 1'b0},
    '{1'b1, 2'b11, 24'h300008, 16'h0000, 16'h7777, 9'h000, 16'h0000, 6'h00, 8'h00, 1'b0, 1'b0},
    '{1'b0, 2'b11, 24'h300002, 16'h5555, 16'h0000, 9'h000, 16'h0000, 6'h00, 8'h00, 1'b0, 1'b0},
    '{1'b0, 2'b01, 24'h600000, 16'h12A5, 16'h0000, 9'h000, 16'h0000, 6'h00, 8'hA5, 1'b1, 1'b0},
    '{1'b0, 2'b11, 24'h600000, 16'h003C, 16'h0000, 9'h000, 16'h0000, 6'h00, 8'h3C, 1'b1, 1'b0},
    '{1'b1, 2'b11, 24'h500000, 16'h0000, 16'h0000, 9'h000, 16'h0000, 6'h00, 8'h3C, 1'b0, 1'b0},
    '{1'b0, 2'b11, 24'h500000, 16'hFFFF, 16'h0000, 9'h000, 16'h0000, 6'h00, 8'h3C, 1'b0, 1'b0},
    '{1'b1, 2'b11, 24'h000100, 16'h0000, 16'h0000, 9'h000, 16'h0000, 6'h00, 8'h3C, 1'b0, 1'b0}
};

`endif

// File: verification/tb_main_bus.sv
// ----------------------------------------
// testbench for the Garegga main bus
// runs each table row as one 68000 cycle and answers
// GP9001 strobes after a random number of cycles
// ----------------------------------------
`include "bus_settings.svh"

module tb_main_bus;
    timeunit 1ns;
    timeprecision 100ps;
    import bus_pkg::*;

    localparam int CLK_PERIOD = 4;

    logic                  CLK96;
    logic                  RESET96;
    logic                  as_n;
    logic                  rw;
    logic                  uds_n;
    logic                  lds_n;
    logic [`BUS_AW-1:0]    addr;
    bus_word_t             wdata;
    bus_word_t             rdata;
    logic                  dtack_n;
    logic                  gp9001_ack;
    bus_word_t             gp9001_dout;
    logic                  gp9001_op_select_reg;
    logic                  gp9001_op_write_reg;
    logic                  gp9001_op_write_ram;
    logic                  gp9001_op_read_ram_h;
    logic                  gp9001_op_read_ram_l;
    logic                  gp9001_op_set_ram_ptr;
    logic [7:0]            soundlatch;
    logic                  z80int;
    logic [9:0]            joystick1;
    logic [9:0]            joystick2;
    logic [3:0]            start_button;
    logic [3:0]            coin_input;
    logic                  service;
    logic                  dip_test;
    logic [7:0]            dipsw_a;
    logic [7:0]            dipsw_b;
    logic [7:0]            dipsw_c;
    logic [8:0]            v;
    logic                  hsync;
    logic                  vsync;
    logic                  fblank;
    logic [`PALRAM_AW-1:0] palram_addr;
    bus_word_t             palram_data;
    int                    ack_delay;   // last wait drawn by the GP9001 model

    `include "bus_vectors.svh"

    garegga_main_bus u_garegga_main_bus (.*);

    always #(CLK_PERIOD / 2) CLK96 = ~CLK96;

    function automatic logic [5:0] strobe_bits();
        return {gp9001_op_select_reg, gp9001_op_write_reg, gp9001_op_write_ram,
                gp9001_op_read_ram_h, gp9001_op_read_ram_l, gp9001_op_set_ram_ptr};
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input bus_word_t exp, input bus_word_t got);
        if (got !== exp)
            stop_with_failure($sformatf("** Error at %0t ns: %s expected %h, got %h",
                                        $time, name, exp, got));
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
        if (got !== exp)
            stop_with_failure($sformatf("** Error at %0t ns: %s expected %h, got %h",
                                        $time, name, exp, got));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp)
            stop_with_failure($sformatf("** Error at %0t ns: %s expected %b, got %b",
                                        $time, name, exp, got));
    endtask

    task automatic check_count(input string name, input int exp, input int got);
        if (got != exp)
            stop_with_failure($sformatf("** Error at %0t ns: %s expected %0d, got %0d",
                                        $time, name, exp, got));
    endtask

    task automatic check_strobes(input string what, input logic [5:0] exp, input logic [5:0] got);
        check_bit({what, " gp9001_op_select_reg"}, exp[5], got[5]);
        check_bit({what, " gp9001_op_write_reg"}, exp[4], got[4]);
        check_bit({what, " gp9001_op_write_ram"}, exp[3], got[3]);
        check_bit({what, " gp9001_op_read_ram_h"}, exp[2], got[2]);
        check_bit({what, " gp9001_op_read_ram_l"}, exp[1], got[1]);
        check_bit({what, " gp9001_op_set_ram_ptr"}, exp[0], got[0]);
    endtask

    // runs one master cycle and holds as_n low until dtack_n is seen
    task automatic run_access(input access_vec_t t);
        int         cycles;
        int         int_cycles;
        int         exp_cycles;
        logic [5:0] seen;
        logic [5:0] now;
        logic       acked;
        cycles     = 0;
        int_cycles = 0;
        seen       = 6'h00;
        acked      = 1'b0;
        @(posedge CLK96);
        v           <= t.v_in;
        gp9001_dout <= t.gdout;
        addr        <= t.byte_addr[23:1];
        rw          <= t.rw;
        uds_n       <= ~t.ben[1];
        lds_n       <= ~t.ben[0];
        wdata       <= t.wdata;
        as_n        <= 1'b0;
        @(posedge CLK96);                  // first edge to see as_n low
        do begin
            @(posedge CLK96);
            cycles++;
            @(negedge CLK96);
            now = strobe_bits();
            if (seen != 6'h00 && !acked)
                check_strobes("held", t.exp_strobe, now);   // no drop before the ack
            else
                check_strobes("stray", 6'h00, now & ~t.exp_strobe);
            seen  = seen | now;
            acked = acked | gp9001_ack;
            if (z80int)
                int_cycles++;
        end while (dtack_n);
        exp_cycles = (t.exp_strobe != 6'h00) ? 3 + ack_delay : 3;
        check_strobes("raised", t.exp_strobe, seen);
        check_strobes("cleared", 6'h00, now);
        check_count("dtack_n latency", exp_cycles, cycles);
        if (t.rw)
            check_word("rdata", t.exp_rdata, rdata);
        check_count("z80int high cycles", int'(t.exp_int), int_cycles);
        check_byte("soundlatch", t.exp_latch, soundlatch);
        @(posedge CLK96);
        as_n  <= 1'b1;
        rw    <= 1'b1;
        uds_n <= 1'b1;
        lds_n <= 1'b1;
        @(posedge CLK96);
        @(negedge CLK96);
        check_bit("dtack_n after release", 1'b1, dtack_n);
        if (t.pal_chk) begin
            @(posedge CLK96);
            palram_addr <= t.byte_addr[11:1];
            @(posedge CLK96);
            @(negedge CLK96);
            check_word("palram_data", t.exp_rdata, palram_data);
        end
    endtask

    // GP9001 stand-in that acks any raised strobe after 1 to 6 cycles
    initial begin : gp9001_model
        void'($urandom(63975));
        gp9001_ack = 1'b0;
        ack_delay  = 0;
        forever begin
            @(negedge CLK96);
            if (strobe_bits() != 6'h00 && !gp9001_ack) begin
                ack_delay = $urandom_range(6, 1);
                repeat (ack_delay) @(posedge CLK96);
                gp9001_ack <= 1'b1;
                @(posedge CLK96);
                gp9001_ack <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(NUM_VEC * 20 * CLK_PERIOD);
        stop_with_failure("watchdog expired, the bus cycles did not all complete in time");
    end

    initial begin
        CLK96        = 1'b0;
        RESET96      = 1'b1;
        as_n         = 1'b1;
        rw           = 1'b1;
        uds_n        = 1'b1;
        lds_n        = 1'b1;
        addr         = '0;
        wdata        = '0;
        gp9001_dout  = '0;
        joystick1    = JOY1;
        joystick2    = JOY2;
        start_button = START_IN;
        coin_input   = COIN_IN;
        service      = SERVICE_IN;
        dip_test     = TEST_IN;
        dipsw_a      = DSW_A;
        dipsw_b      = DSW_B;
        dipsw_c      = DSW_C;
        v            = '0;
        hsync        = HSYNC_IN;
        vsync        = VSYNC_IN;
        fblank       = FBLANK_IN;
        palram_addr  = '0;
        repeat (5) @(posedge CLK96);
        RESET96 <= 1'b0;
        @(negedge CLK96);
        check_bit("dtack_n after reset", 1'b1, dtack_n);
        check_strobes("reset", 6'h00, strobe_bits());
        check_bit("z80int after reset", 1'b0, z80int);
        check_byte("soundlatch after reset", 8'h00, soundlatch);
        check_word("rdata after reset", 16'h0000, rdata);
        for (int i = 0; i < NUM_VEC; i++)
            run_access(VECTORS[i]);
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: tb.f
+incdir+design
+incdir+verification
design/bus_pkg.sv
design/cabinet_pkg.sv
design/bus_decode.sv
design/cpu_ram.sv
design/access_execute.sv
design/read_result.sv
design/garegga_main_bus.sv
verification/tb_main_bus.sv
